// ==== source/dac_pkg.sv ====
// shared constants, register map and DAC word layout for the
// dual nanoDAC SPI subsystem
package dac_pkg;

    ////////////////////////////////////////
    // sizing

    localparam int N_DAC            = 2;
    localparam int DAC_FRAME_BITS   = 16;
    localparam int SCLK_HALF_CYCLES = 2;
    localparam int REG_ADDR_W       = 2;
    localparam int REG_DATA_W       = 16;
    localparam int DAC_GAIN_W       = 8;
    localparam int SEL_W            = $clog2(N_DAC);
    localparam int DIV_W            = $clog2(SCLK_HALF_CYCLES + 1);
    // bits 0..16 plus one tail cycle after select release
    localparam int BIT_CNT_W        = $clog2(DAC_FRAME_BITS + 2);

    ////////////////////////////////////////
    // register map

    localparam logic [REG_ADDR_W-1:0] ADDR_MODULE_ID      = 2'd0;
    localparam logic [REG_ADDR_W-1:0] ADDR_MODULE_VERSION = 2'd1;
    localparam logic [REG_ADDR_W-1:0] ADDR_DAC_REG        = 2'd2;
    localparam logic [REG_ADDR_W-1:0] ADDR_EN_MMI_CTRL    = 2'd3;

    localparam logic [REG_DATA_W-1:0] MODULE_VERSION = 16'd1;

    // per instance identity and power-up words
    localparam logic [REG_DATA_W-1:0] DAC0_MODULE_ID = 16'hd0a0;
    localparam logic [REG_DATA_W-1:0] DAC1_MODULE_ID = 16'hd0a1;
    localparam logic [REG_DATA_W-1:0] DAC0_DEFAULT   = 16'h2000;
    localparam logic [REG_DATA_W-1:0] DAC1_DEFAULT   = 16'h1fc0;

    // request sequencer encodings
    localparam int SEQ_W = 2;
    localparam logic [SEQ_W-1:0] ST_IDLE  = 2'd0;
    localparam logic [SEQ_W-1:0] ST_REQ   = 2'd1;
    localparam logic [SEQ_W-1:0] ST_AGAIN = 2'd2;

    // DAC register, seen whole or split into mode / data / reserved
    typedef union packed {
        logic [REG_DATA_W-1:0] raw;
        struct packed {
            logic [1:0]            mode;
            logic [DAC_GAIN_W-1:0] data;
            logic [5:0]            reserved;
        } fields;
    } dac_word_u;

endpackage

// ==== source/dac_reg_ctrl.sv ====
// per-DAC controller: register map with strobe access and the
// sequencer that asks for SPI frames, merging updates in flight
`timescale 1ns/10ps

module dac_reg_ctrl #(
    parameter logic [dac_pkg::REG_DATA_W-1:0] MODULE_ID   = 16'h0000,
    parameter logic [dac_pkg::REG_DATA_W-1:0] DAC_DEFAULT = 16'h0000
) (
    input  logic                              clk_ifc,
    input  logic                              set_default_on_reset,

    // register access
    input  logic                              wr_stb,
    input  logic                              rd_stb,
    input  logic [dac_pkg::REG_ADDR_W-1:0]    addr,
    input  logic [dac_pkg::REG_DATA_W-1:0]    wdata,
    output logic                              rd_valid,
    output logic [dac_pkg::REG_DATA_W-1:0]    rdata,

    // control inputs
    input  logic                              en_mmi_ctrl,
    input  logic [dac_pkg::DAC_GAIN_W-1:0]    gain,
    input  logic                              gain_stb,

    // arbiter side
    output logic                              req,
    output dac_pkg::dac_word_u                req_word,
    input  logic                              grant,
    input  logic                              done,

    // status
    output logic                              updated_stb,
    output logic                              initdone
);

    import dac_pkg::*;

    logic [SEQ_W-1:0] state;
    dac_word_u        dac_reg;
    dac_word_u        dac_next;
    logic             wr_hit;
    logic             gain_hit;
    logic             upd;
    logic             boot_pend;
    logic             load_word;
    logic             frame_done;

    ////////////////////////////////////////
    // register update

    // software owns the register while enabled, the gain input otherwise
    assign wr_hit     = wr_stb && (addr == ADDR_DAC_REG) && en_mmi_ctrl;
    assign gain_hit   = gain_stb && !en_mmi_ctrl;
    assign upd        = wr_hit || gain_hit;
    assign frame_done = done && grant;
    assign req        = (state != ST_IDLE);

    always_comb begin
        dac_next = dac_reg;
        if (wr_hit) begin
            dac_next.raw = wdata;
        end else if (gain_hit) begin
            dac_next.fields.data = gain;
        end
    end

    ////////////////////////////////////////
    // frame sequencer

    // new frame word is taken from the value being written this cycle
    always_comb begin
        case (state)
            ST_IDLE:  load_word = upd || boot_pend;
            ST_REQ:   load_word = frame_done && upd;
            ST_AGAIN: load_word = frame_done;
            default:  load_word = 1'b0;
        endcase
    end

    always_ff @(posedge clk_ifc) begin
        if (set_default_on_reset) begin
            state       <= ST_IDLE;
            boot_pend   <= 1'b1;
            updated_stb <= 1'b0;
            initdone    <= 1'b0;
            dac_reg.raw <= DAC_DEFAULT;
        end else begin
            dac_reg     <= dac_next;
            updated_stb <= frame_done;
            if (frame_done) begin
                initdone <= 1'b1;
            end
            if (load_word) begin
                boot_pend <= 1'b0;
            end
            case (state)
                ST_IDLE: begin
                    if (load_word) begin
                        state <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (frame_done) begin
                        // an update landing with done goes straight out
                        state <= upd ? ST_REQ : ST_IDLE;
                    end else if (upd) begin
                        state <= ST_AGAIN;
                    end
                end
                ST_AGAIN: begin
                    if (frame_done) begin
                        state <= ST_REQ;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_ifc) begin
        if (load_word) begin
            req_word <= dac_next;
        end
    end

    ////////////////////////////////////////
    // read port

    always_ff @(posedge clk_ifc) begin
        if (set_default_on_reset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_stb;
        end
    end

    always_ff @(posedge clk_ifc) begin
        if (rd_stb) begin
            case (addr)
                ADDR_MODULE_ID:      rdata <= MODULE_ID;
                ADDR_MODULE_VERSION: rdata <= MODULE_VERSION;
                ADDR_DAC_REG:        rdata <= dac_reg.raw;
                ADDR_EN_MMI_CTRL:    rdata <= {{(REG_DATA_W-1){1'b0}}, en_mmi_ctrl};
                default:             rdata <= '0;
            endcase
        end
    end

    // arbiter must only complete a frame this controller asked for
    a_done_needs_req: assert property (
        @(posedge clk_ifc) disable iff (set_default_on_reset)
        done |-> req
    ) else $error("done seen without an outstanding request");

endmodule

// ==== source/spi_arbiter.sv ====
// round-robin arbiter handing the single SPI shift engine to one
// DAC controller at a time
`timescale 1ns/10ps

module spi_arbiter (
    input  logic                           clk_ifc,
    input  logic                           set_default_on_reset,

    // controller side
    input  logic [dac_pkg::N_DAC-1:0]      req,
    input  dac_pkg::dac_word_u             req_word [dac_pkg::N_DAC],
    output logic [dac_pkg::N_DAC-1:0]      grant,
    output logic [dac_pkg::N_DAC-1:0]      done,

    // engine side
    output logic                           start,
    output dac_pkg::dac_word_u             word,
    output logic [dac_pkg::SEL_W-1:0]      ss_sel,
    input  logic                           eng_done
);

    import dac_pkg::*;

    logic             busy;
    logic [SEL_W-1:0] last;
    logic [SEL_W-1:0] pick;
    logic             pick_valid;

    // search starts one past the last served peer
    always_comb begin : rr_pick
        int cand;
        pick_valid = 1'b0;
        pick       = last;
        for (int i = 1; i <= N_DAC; i++) begin
            cand = (int'(last) + i) % N_DAC;
            if (!pick_valid && req[cand]) begin
                pick_valid = 1'b1;
                pick       = SEL_W'(cand);
            end
        end
    end

    // winner stays in last for the whole frame
    always_comb begin
        grant = '0;
        if (busy) begin
            grant[last] = 1'b1;
        end
    end

    assign done   = grant & {N_DAC{eng_done}};
    assign word   = req_word[last];
    assign ss_sel = last;

    always_ff @(posedge clk_ifc) begin
        if (set_default_on_reset) begin
            busy  <= 1'b0;
            last  <= SEL_W'(N_DAC - 1);
            start <= 1'b0;
        end else begin
            start <= 1'b0;
            if (busy) begin
                if (eng_done) begin
                    busy <= 1'b0;
                end
            end else if (pick_valid) begin
                busy  <= 1'b1;
                last  <= pick;
                start <= 1'b1;
            end
        end
    end

    // a grant goes to at most one peer, and only to one still asking
    a_grant_onehot: assert property (
        @(posedge clk_ifc) disable iff (set_default_on_reset)
        $onehot0(grant) && ((grant & ~req) == '0)
    ) else $error("grant not one-hot or given to an idle peer");

endmodule

// ==== source/spi_shift_engine.sv ====
// SPI shift engine: one 16-bit frame MSB first, sclk idling high,
// data changing on rising edges and one select line per DAC
`timescale 1ns/10ps

module spi_shift_engine (
    input  logic                          clk_ifc,
    input  logic                          set_default_on_reset,

    input  logic                          start,
    input  dac_pkg::dac_word_u            word,
    input  logic [dac_pkg::SEL_W-1:0]     ss_sel,
    output logic                          done,

    output logic                          sclk,
    output logic                          mosi,
    output logic [dac_pkg::N_DAC-1:0]     ss_n
);

    import dac_pkg::*;

    logic                      busy;
    logic [DIV_W-1:0]          div;
    logic [BIT_CNT_W-1:0]      bit_cnt;
    logic [DAC_FRAME_BITS-1:0] shreg;
    logic                      launch;
    logic                      tick;
    logic                      in_tail;

    assign launch  = start && !busy;
    assign tick    = busy && (div == DIV_W'(SCLK_HALF_CYCLES - 1));
    // one spare cycle with select high before done
    assign in_tail = (bit_cnt == BIT_CNT_W'(DAC_FRAME_BITS + 1));
    assign mosi    = shreg[DAC_FRAME_BITS-1];

    ////////////////////////////////////////
    // sclk and select timing

    always_ff @(posedge clk_ifc) begin
        if (set_default_on_reset) begin
            busy    <= 1'b0;
            div     <= '0;
            bit_cnt <= '0;
            sclk    <= 1'b1;
            ss_n    <= '1;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (launch) begin
                busy    <= 1'b1;
                // preload so the first fall lands SCLK_HALF_CYCLES after start
                div     <= DIV_W'(SCLK_HALF_CYCLES - 1);
                bit_cnt <= '0;
                ss_n    <= ~(N_DAC'(1) << ss_sel);
            end else if (busy) begin
                if (in_tail) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else if (tick) begin
                    div <= '0;
                    if (!sclk) begin
                        sclk    <= 1'b1;
                        bit_cnt <= bit_cnt + 1'b1;
                    end else if (bit_cnt == BIT_CNT_W'(DAC_FRAME_BITS)) begin
                        // last high half done, release the DAC
                        ss_n    <= '1;
                        bit_cnt <= bit_cnt + 1'b1;
                    end else begin
                        sclk <= 1'b0;
                    end
                end else begin
                    div <= div + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////
    // data path

    // shift on the rising edge so mosi is steady across the fall
    always_ff @(posedge clk_ifc) begin
        if (launch) begin
            shreg <= word.raw;
        end else if (tick && !sclk) begin
            shreg <= shreg << 1;
        end
    end

    a_start_idle: assert property (
        @(posedge clk_ifc) disable iff (set_default_on_reset)
        start |-> !busy
    ) else $error("start while a frame is still in flight");

endmodule

// ==== source/dac_subsystem_top.sv ====
// dual nanoDAC subsystem: two register controllers sharing one
// SPI shift engine through a round-robin arbiter
`timescale 1ns/10ps

module dac_subsystem_top (
    input  logic                            clk_ifc,
    input  logic                            set_default_on_reset,

    // DAC 0 register and gain ports
    input  logic                            dac0_wr_stb,
    input  logic                            dac0_rd_stb,
    input  logic [dac_pkg::REG_ADDR_W-1:0]  dac0_addr,
    input  logic [dac_pkg::REG_DATA_W-1:0]  dac0_wdata,
    output logic                            dac0_rd_valid,
    output logic [dac_pkg::REG_DATA_W-1:0]  dac0_rdata,
    input  logic                            dac0_en_mmi_ctrl,
    input  logic [dac_pkg::DAC_GAIN_W-1:0]  dac0_gain,
    input  logic                            dac0_gain_stb,
    output logic                            dac0_updated_stb,
    output logic                            dac0_initdone,

    // DAC 1 register and gain ports
    input  logic                            dac1_wr_stb,
    input  logic                            dac1_rd_stb,
    input  logic [dac_pkg::REG_ADDR_W-1:0]  dac1_addr,
    input  logic [dac_pkg::REG_DATA_W-1:0]  dac1_wdata,
    output logic                            dac1_rd_valid,
    output logic [dac_pkg::REG_DATA_W-1:0]  dac1_rdata,
    input  logic                            dac1_en_mmi_ctrl,
    input  logic [dac_pkg::DAC_GAIN_W-1:0]  dac1_gain,
    input  logic                            dac1_gain_stb,
    output logic                            dac1_updated_stb,
    output logic                            dac1_initdone,

    // SPI pins
    output logic                            sclk,
    output logic                            mosi,
    output logic [dac_pkg::N_DAC-1:0]       ss_n
);

    import dac_pkg::*;

    logic [N_DAC-1:0] req;
    logic [N_DAC-1:0] grant;
    logic [N_DAC-1:0] arb_done;
    dac_word_u        req_word [N_DAC];
    logic             start;
    logic             eng_done;
    dac_word_u        eng_word;
    logic [SEL_W-1:0] ss_sel;

    dac_reg_ctrl #(
        .MODULE_ID   (DAC0_MODULE_ID),
        .DAC_DEFAULT (DAC0_DEFAULT)
    ) i_ctrl0 (
        .clk_ifc              (clk_ifc),
        .set_default_on_reset (set_default_on_reset),
        .wr_stb               (dac0_wr_stb),
        .rd_stb               (dac0_rd_stb),
        .addr                 (dac0_addr),
        .wdata                (dac0_wdata),
        .rd_valid             (dac0_rd_valid),
        .rdata                (dac0_rdata),
        .en_mmi_ctrl          (dac0_en_mmi_ctrl),
        .gain                 (dac0_gain),
        .gain_stb             (dac0_gain_stb),
        .req                  (req[0]),
        .req_word             (req_word[0]),
        .grant                (grant[0]),
        .done                 (arb_done[0]),
        .updated_stb          (dac0_updated_stb),
        .initdone             (dac0_initdone)
    );

    dac_reg_ctrl #(
        .MODULE_ID   (DAC1_MODULE_ID),
        .DAC_DEFAULT (DAC1_DEFAULT)
    ) i_ctrl1 (
        .clk_ifc              (clk_ifc),
        .set_default_on_reset (set_default_on_reset),
        .wr_stb               (dac1_wr_stb),
        .rd_stb               (dac1_rd_stb),
        .addr                 (dac1_addr),
        .wdata                (dac1_wdata),
        .rd_valid             (dac1_rd_valid),
        .rdata                (dac1_rdata),
        .en_mmi_ctrl          (dac1_en_mmi_ctrl),
        .gain                 (dac1_gain),
        .gain_stb             (dac1_gain_stb),
        .req                  (req[1]),
        .req_word             (req_word[1]),
        .grant                (grant[1]),
        .done                 (arb_done[1]),
        .updated_stb          (dac1_updated_stb),
        .initdone             (dac1_initdone)
    );

    spi_arbiter i_arb (
        .clk_ifc              (clk_ifc),
        .set_default_on_reset (set_default_on_reset),
        .req                  (req),
        .req_word             (req_word),
        .grant                (grant),
        .done                 (arb_done),
        .start                (start),
        .word                 (eng_word),
        .ss_sel               (ss_sel),
        .eng_done             (eng_done)
    );

    spi_shift_engine i_eng (
        .clk_ifc              (clk_ifc),
        .set_default_on_reset (set_default_on_reset),
        .start                (start),
        .word                 (eng_word),
        .ss_sel               (ss_sel),
        .done                 (eng_done),
        .sclk                 (sclk),
        .mosi                 (mosi),
        .ss_n                 (ss_n)
    );

endmodule

// ==== tests/clk_gen.sv ====
// testbench clock and power-on reset source
`timescale 1ns/10ps

module clk_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_ifc,
    output logic set_default_on_reset
);

    initial begin
        clk_ifc = 1'b0;
        forever #(PERIOD_NS / 2) clk_ifc = ~clk_ifc;
    end

    // released just after an edge, like every other input
    initial begin
        set_default_on_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_ifc);
        #1;
        set_default_on_reset = 1'b0;
    end

endmodule

// ==== tests/dac_tb.sv ====
// testbench for the dual nanoDAC subsystem: replays the case file,
// captures SPI frames per select line and checks them
`timescale 1ns/10ps

module dac_tb;

    import dac_pkg::*;

    localparam int          CASE_MAX        = 128;
    localparam int          CYCLES_PER_CASE = 200;
    localparam int          RESET_CYCLES    = 16;
    localparam logic [31:0] RAND_SEED       = 32'h50d1b554;

    localparam logic [3:0] OP_WRITE      = 4'h0;
    localparam logic [3:0] OP_READ       = 4'h1;
    localparam logic [3:0] OP_GAIN       = 4'h2;
    localparam logic [3:0] OP_ENABLE     = 4'h3;
    localparam logic [3:0] OP_WAIT_UPD   = 4'h4;
    localparam logic [3:0] OP_FRAME      = 4'h5;
    localparam logic [3:0] OP_WRITE_BOTH = 4'h6;
    localparam logic [3:0] OP_IDLE       = 4'h7;
    localparam logic [3:0] OP_QUIET      = 4'h8;
    localparam logic [3:0] OP_INITDONE   = 4'h9;
    localparam logic [3:0] OP_END        = 4'hf;

    // one line of the case file
    typedef struct packed {
        logic [3:0]            op;
        logic [3:0]            dac;
        logic [3:0]            addr;
        logic [REG_DATA_W-1:0] data;
        logic [REG_DATA_W-1:0] data2;
    } case_t;

    logic                  clk_ifc;
    logic                  set_default_on_reset;
    logic [N_DAC-1:0]      wr_stb;
    logic [N_DAC-1:0]      rd_stb;
    logic [REG_ADDR_W-1:0] addr [N_DAC];
    logic [REG_DATA_W-1:0] wdata [N_DAC];
    logic [N_DAC-1:0]      en_mmi_ctrl;
    logic [DAC_GAIN_W-1:0] gain [N_DAC];
    logic [N_DAC-1:0]      gain_stb;
    logic                  rd_valid [N_DAC];
    logic [REG_DATA_W-1:0] rdata [N_DAC];
    logic                  updated_stb [N_DAC];
    logic                  initdone [N_DAC];
    logic                  sclk;
    logic                  mosi;
    logic [N_DAC-1:0]      ss_n;

    logic [$bits(case_t)-1:0] cases [CASE_MAX];
    int        n_cases = 0;
    int        upd_seen [N_DAC] = '{0, 0};
    int        upd_used [N_DAC] = '{0, 0};
    dac_word_u frames0 [$];
    dac_word_u frames1 [$];
    dac_word_u cap_word;
    int        cap_bits = 0;
    int        cap_line = 0;

    clk_gen #(.PERIOD_NS(8), .RESET_CYCLES(RESET_CYCLES)) i_clk_gen (
        .clk_ifc              (clk_ifc),
        .set_default_on_reset (set_default_on_reset)
    );

    dac_subsystem_top i_dut (
        .clk_ifc              (clk_ifc),
        .set_default_on_reset (set_default_on_reset),
        .dac0_wr_stb          (wr_stb[0]),
        .dac0_rd_stb          (rd_stb[0]),
        .dac0_addr            (addr[0]),
        .dac0_wdata           (wdata[0]),
        .dac0_rd_valid        (rd_valid[0]),
        .dac0_rdata           (rdata[0]),
        .dac0_en_mmi_ctrl     (en_mmi_ctrl[0]),
        .dac0_gain            (gain[0]),
        .dac0_gain_stb        (gain_stb[0]),
        .dac0_updated_stb     (updated_stb[0]),
        .dac0_initdone        (initdone[0]),
        .dac1_wr_stb          (wr_stb[1]),
        .dac1_rd_stb          (rd_stb[1]),
        .dac1_addr            (addr[1]),
        .dac1_wdata           (wdata[1]),
        .dac1_rd_valid        (rd_valid[1]),
        .dac1_rdata           (rdata[1]),
        .dac1_en_mmi_ctrl     (en_mmi_ctrl[1]),
        .dac1_gain            (gain[1]),
        .dac1_gain_stb        (gain_stb[1]),
        .dac1_updated_stb     (updated_stb[1]),
        .dac1_initdone        (initdone[1]),
        .sclk                 (sclk),
        .mosi                 (mosi),
        .ss_n                 (ss_n)
    );

    ////////////////////////////////////////
    // reporting and compares

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic compare_word(input string name, input dac_word_u got, input dac_word_u exp);
        if (got.raw !== exp.raw) begin
            fail_run($sformatf("[ERROR] %0t %s got %h expected %h",
                               $time, name, got.raw, exp.raw));
        end
    endtask

    task automatic compare_rdata(input string name, input logic [REG_DATA_W-1:0] got,
                                 input logic [REG_DATA_W-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    ////////////////////////////////////////
    // monitors

    // frames are shifted in on every sclk fall while a select is low
    always @(negedge sclk) begin
        if (!set_default_on_reset) begin
            if (ss_n == '1) begin
                fail_run("sclk fell while no select line was low");
            end else if (cap_bits != 0 && cap_line != (ss_n[0] ? 1 : 0)) begin
                fail_run("select line changed in the middle of a frame");
            end else begin
                cap_line     = ss_n[0] ? 1 : 0;
                cap_word.raw = {cap_word.raw[DAC_FRAME_BITS-2:0], mosi};
                cap_bits     = cap_bits + 1;
                if (cap_bits == DAC_FRAME_BITS) begin
                    if (cap_line == 0) begin
                        frames0.push_back(cap_word);
                    end else begin
                        frames1.push_back(cap_word);
                    end
                    cap_bits = 0;
                end
            end
        end
    end

    // frames must never overlap
    always @(negedge clk_ifc) begin
        if (!set_default_on_reset && $countones(~ss_n) > 1) begin
            fail_run("more than one ss_n line low at the same time");
        end
    end

    always @(posedge clk_ifc) begin
        for (int k = 0; k < N_DAC; k++) begin
            if (!set_default_on_reset && updated_stb[k]) begin
                upd_seen[k] = upd_seen[k] + 1;
            end
        end
    end

    initial begin : watchdog
        wait (n_cases > 0);
        repeat (n_cases * CYCLES_PER_CASE + RESET_CYCLES) @(posedge clk_ifc);
        fail_run("timeout: the cases did not finish within their cycle budget");
    end

    ////////////////////////////////////////
    // drivers

    task automatic next_cycle();
        @(posedge clk_ifc);
        #1;
    endtask

    task automatic write_reg(input int d, input logic [REG_ADDR_W-1:0] a,
                             input logic [REG_DATA_W-1:0] v);
        wr_stb[d] = 1'b1;
        addr[d]   = a;
        wdata[d]  = v;
        next_cycle();
        wr_stb[d] = 1'b0;
    endtask

    task automatic write_both(input logic [REG_ADDR_W-1:0] a, input logic [REG_DATA_W-1:0] v0,
                              input logic [REG_DATA_W-1:0] v1);
        wr_stb   = '1;
        addr[0]  = a;
        addr[1]  = a;
        wdata[0] = v0;
        wdata[1] = v1;
        next_cycle();
        wr_stb   = '0;
    endtask

    // rd_valid must be high in the cycle after rd_stb and only then
    task automatic read_check(input int d, input logic [REG_ADDR_W-1:0] a,
                              input logic [REG_DATA_W-1:0] exp);
        compare_bit($sformatf("dac%0d_rd_valid", d), rd_valid[d], 1'b0);
        rd_stb[d] = 1'b1;
        addr[d]   = a;
        next_cycle();
        rd_stb[d] = 1'b0;
        compare_bit($sformatf("dac%0d_rd_valid", d), rd_valid[d], 1'b1);
        compare_rdata($sformatf("dac%0d_rdata", d), rdata[d], exp);
        next_cycle();
        compare_bit($sformatf("dac%0d_rd_valid", d), rd_valid[d], 1'b0);
    endtask

    task automatic pulse_gain(input int d, input logic [DAC_GAIN_W-1:0] g);
        gain[d]     = g;
        gain_stb[d] = 1'b1;
        next_cycle();
        gain_stb[d] = 1'b0;
    endtask

    task automatic wait_update(input int d);
        while (upd_seen[d] == upd_used[d]) begin
            next_cycle();
        end
        upd_used[d] = upd_used[d] + 1;
    endtask

    task automatic expect_frame(input int d, input dac_word_u exp);
        dac_word_u got;
        int        left;
        left = (d == 0) ? frames0.size() : frames1.size();
        if (left == 0) begin
            fail_run($sformatf("no frame was captured on ss_n[%0d] by %0t", d, $time));
        end else begin
            got = (d == 0) ? frames0.pop_front() : frames1.pop_front();
            compare_word($sformatf("dac%0d frame", d), got, exp);
        end
    endtask

    task automatic expect_quiet(input int d);
        int left;
        left = (d == 0) ? frames0.size() : frames1.size();
        if (left != 0) begin
            fail_run($sformatf("%0d unexpected frame(s) on ss_n[%0d]", left, d));
        end else if (upd_seen[d] != upd_used[d]) begin
            fail_run($sformatf("unexpected updated_stb pulse from DAC %0d", d));
        end
    endtask

    task automatic run_case(input case_t c);
        int        d;
        dac_word_u w;
        d     = int'(c.dac[0]);
        w.raw = c.data;
        case (c.op)
            OP_WRITE:      write_reg(d, c.addr[REG_ADDR_W-1:0], c.data);
            OP_READ:       read_check(d, c.addr[REG_ADDR_W-1:0], c.data);
            OP_GAIN:       pulse_gain(d, c.data[DAC_GAIN_W-1:0]);
            OP_WAIT_UPD:   wait_update(d);
            OP_FRAME:      expect_frame(d, w);
            OP_WRITE_BOTH: write_both(c.addr[REG_ADDR_W-1:0], c.data, c.data2);
            OP_IDLE:       repeat (int'(c.data)) next_cycle();
            OP_QUIET:      expect_quiet(d);
            OP_INITDONE:   compare_bit($sformatf("dac%0d_initdone", d), initdone[d], c.data[0]);
            OP_ENABLE: begin
                en_mmi_ctrl[d] = c.data[0];
                next_cycle();
            end
            default:       fail_run($sformatf("unknown op %h in the case file", c.op));
        endcase
    endtask

    ////////////////////////////////////////
    // main sequence

    initial begin : run_cases
        case_t cur;
        int    count;
        void'($urandom(RAND_SEED));
        wr_stb      = '0;
        rd_stb      = '0;
        gain_stb    = '0;
        en_mmi_ctrl = '0;
        for (int k = 0; k < N_DAC; k++) begin
            addr[k]  = '0;
            wdata[k] = '0;
            gain[k]  = '0;
        end
        for (int i = 0; i < CASE_MAX; i++) begin
            cases[i] = '1;
        end
        $readmemh("tests/dac_cases.txt", cases);
        // unfilled entries keep the all-ones end marker
        count = CASE_MAX;
        for (int i = CASE_MAX - 1; i >= 0; i--) begin
            cur = cases[i];
            if (cur.op == OP_END) begin
                count = i;
            end
        end
        if (count == 0) begin
            fail_run("no cases could be read from tests/dac_cases.txt");
        end else begin
            n_cases = count;
            @(negedge set_default_on_reset);
            next_cycle();
            for (int i = 0; i < count; i++) begin
                cur = cases[i];
                run_case(cur);
                repeat ($urandom % 4) next_cycle();
            end
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

// ==== all.f ====
source/dac_pkg.sv
source/dac_reg_ctrl.sv
source/spi_arbiter.sv
source/spi_shift_engine.sv
source/dac_subsystem_top.sv
tests/clk_gen.sv
tests/dac_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the dual nanoDAC testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
    --top-module dac_tb -Mdir obj_dir -f all.f &&
./obj_dir/Vdac_tb ||
{ echo "simulation build or run failed"; exit 1; }

// ==== tests/dac_cases.txt ====
// columns (hex): op_dac_addr_data_data2, data2 used only by op 6
// op 0 write, 1 read and compare, 2 gain strobe, 3 set enable, 4 wait for update,
// 5 expect frame, 6 write both DACs, 7 idle cycles, 8 nothing pending, 9 initdone
// power-up frames
4_0_0_0000_0000
4_1_0_0000_0000
5_0_0_2000_0000
5_1_0_1fc0_0000
9_0_0_0001_0000
9_1_0_0001_0000
// identity and register reads
1_0_0_d0a0_0000
1_1_0_d0a1_0000
1_0_1_0001_0000
1_1_1_0001_0000
1_0_2_2000_0000
1_1_2_1fc0_0000
1_0_3_0000_0000
// software write with the enable high
3_0_0_0001_0000
1_0_3_0001_0000
0_0_2_abc0_0000
4_0_0_0000_0000
5_0_0_abc0_0000
// gain strobe ignored while software owns the register
2_0_0_0055_0000
7_0_0_0064_0000
8_0_0_0000_0000
1_0_2_abc0_0000
// enable low: write ignored, gain replaces the data field only
3_0_0_0000_0000
0_0_2_1234_0000
2_0_0_0042_0000
4_0_0_0000_0000
5_0_0_9080_0000
1_0_2_9080_0000
// write to an id address changes nothing
3_1_0_0001_0000
0_1_0_ffff_0000
1_1_0_d0a1_0000
// burst to DAC1 merges into two frames
0_1_2_1111_0000
0_1_2_2222_0000
0_1_2_3333_0000
4_1_0_0000_0000
4_1_0_0000_0000
5_1_0_1111_0000
5_1_0_3333_0000
7_1_0_0064_0000
8_1_0_0000_0000
// both DACs updated in the same cycle
3_0_0_0001_0000
6_0_2_4444_5555
4_0_0_0000_0000
4_1_0_0000_0000
5_0_0_4444_0000
5_1_0_5555_0000
1_1_2_5555_0000
1_0_2_4444_0000
8_0_0_0000_0000
8_1_0_0000_0000
9_0_0_0001_0000
9_1_0_0001_0000
